// ==== files.f ====
+incdir+rtl
rtl/mc_pkg.sv
rtl/burst_allocator.sv
rtl/burst_slot.sv
rtl/ddr5_cmd_encoder.sv
rtl/return_scheduler.sv
rtl/burst_handler.sv
tb/burst_handler_checker.sv
tb/burst_handler_tb.sv

// ==== rtl/burst_allocator.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "mc_cfg.svh"

module burst_allocator (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        arb_valid,
	input  logic [`MC_ADDR_W-1:0]                       arb_addr,
	input  mc_pkg::req_type_t                           arb_type,
	input  mc_pkg::burst_state_t [`MC_NUM_BURSTS-1:0]   slot_state,
	input  logic [`MC_NUM_BURSTS-1:0][`MC_BADDR_W-1:0]  slot_addr,
	output logic [`MC_NUM_BURSTS-1:0]                   slot_start,
	output logic [`MC_NUM_BURSTS-1:0]                   slot_fill,
	output logic [`MC_NUM_BURSTS-1:0]                   slot_close,
	output logic [`MC_NUM_BURSTS-1:0]                   slot_almost,
	output logic [$clog2(`MC_BURST_LEN)-1:0]            req_beat,
	output logic [$clog2(`MC_NUM_BURSTS):0]             empty_bursts
);
	localparam int SLOT_W = $clog2(`MC_NUM_BURSTS);

	logic [SLOT_W-1:0] open_slot; // slot being filled
	logic              open_valid;
	mc_pkg::req_type_t open_type;
	logic [2:0]        merge_cnt; // merges since start
	logic [SLOT_W-1:0] free_slot;
	logic              free_found;
	logic              open_live;
	logic              merge;
	logic              start;

	// lowest empty slot, plus empty count for the arbiter
	always_comb begin
		free_slot = '0;
		free_found = 1'b0;
		empty_bursts = '0;
		for (int i = `MC_NUM_BURSTS - 1; i >= 0; i--) begin // walk down, lowest wins
			if (slot_state[i] == mc_pkg::empty) begin
				free_slot = SLOT_W'(i);
				free_found = 1'b1;
				empty_bursts = empty_bursts + 1'b1;
			end
		end
	end

	assign open_live = open_valid && (slot_state[open_slot] == mc_pkg::filling ||
		slot_state[open_slot] == mc_pkg::almost_done);
	assign merge = arb_valid && open_live && open_type == arb_type &&
		slot_addr[open_slot] == arb_addr[`MC_ADDR_W-1:`MC_ADDR_W-`MC_BADDR_W];
	assign start = arb_valid && !merge && free_found; // no free slot -> request dropped
	assign req_beat = arb_addr[$clog2(`MC_BURST_LEN)-1:0]; // col[3:0] picks the beat

	always_comb begin
		slot_start = '0;
		slot_fill = '0;
		slot_close = '0;
		slot_almost = '0;
		if (start) begin
			slot_start[free_slot] = 1'b1;
			slot_fill[free_slot] = 1'b1; // first request goes in too
		end
		if (merge) begin
			slot_fill[open_slot] = 1'b1;
			slot_almost[open_slot] = (merge_cnt == 3'd7); // eighth merge
		end else if (open_live) begin
			slot_close[open_slot] = 1'b1; // idle cycle or mismatch ends the burst
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			open_valid <= 1'b0;
			open_slot <= '0;
			open_type <= mc_pkg::req_read;
			merge_cnt <= '0;
		end else if (start) begin
			open_valid <= 1'b1;
			open_slot <= free_slot;
			open_type <= arb_type;
			merge_cnt <= '0;
		end else if (merge) begin
			merge_cnt <= merge_cnt + 3'd1;
		end else begin
			open_valid <= 1'b0; // closed this cycle
		end
	end

endmodule

`default_nettype wire

// ==== rtl/burst_handler.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "mc_cfg.svh"

module burst_handler (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        arb_valid,
	input  logic [`MC_ADDR_W-1:0]                       arb_addr,
	input  mc_pkg::req_type_t                           arb_type,
	input  logic [`MC_DATA_W-1:0]                       arb_data,
	input  logic [`MC_INDEX_W-1:0]                      arb_index,
	output logic [$clog2(`MC_NUM_BURSTS):0]             empty_bursts,
	output mc_pkg::burst_state_t [`MC_NUM_BURSTS-1:0]   burst_state,
	output logic [`MC_NUM_BURSTS-1:0][`MC_BADDR_W-1:0]  burst_addr,
	output mc_pkg::req_type_t [`MC_NUM_BURSTS-1:0]      burst_type,
	input  mc_pkg::mem_cmd_t                            cmd,
	input  logic [$clog2(`MC_NUM_BURSTS)-1:0]           cmd_slot,
	output logic                                        cs_n,
	output logic [13:0]                                 ca,
	output logic [`MC_DATA_W-1:0]                       dq_out,
	output logic                                        dq_oe,
	input  logic [`MC_DATA_W-1:0]                       dq_in,
	output logic                                        ret_valid,
	output mc_pkg::req_type_t                           ret_type,
	output logic [`MC_DATA_W-1:0]                       ret_data,
	output logic [`MC_INDEX_W-1:0]                      ret_index
);
	localparam int N = `MC_NUM_BURSTS;

	// allocator strobes, one bit per slot
	logic [N-1:0]                          slot_start;
	logic [N-1:0]                          slot_fill;
	logic [N-1:0]                          slot_close;
	logic [N-1:0]                          slot_almost;
	logic [$clog2(`MC_BURST_LEN)-1:0]      req_beat;
	// encoder side
	logic [N-1:0]                          data_start;
	logic [N-1:0]                          beat_en;
	logic [N-1:0]                          done;
	logic [$clog2(`MC_BURST_LEN)-1:0]      beat_idx;
	// return side
	logic [N-1:0]                          ret_take;
	logic [N-1:0]                          ret_free;
	logic [$clog2(`MC_BURST_LEN)-1:0]      ret_beat;
	logic [N-1:0][`MC_BURST_LEN-1:0]       slot_mask;
	logic [N-1:0][`MC_DATA_W-1:0]          slot_beat_word;
	logic [N-1:0][`MC_DATA_W-1:0]          slot_ret_word;
	logic [N-1:0][`MC_INDEX_W-1:0]         slot_ret_idx;

	burst_allocator u_alloc (
		.clk(clk), .rst_n(rst_n),
		.arb_valid(arb_valid), .arb_addr(arb_addr), .arb_type(arb_type),
		.slot_state(burst_state), .slot_addr(burst_addr),
		.slot_start(slot_start), .slot_fill(slot_fill), .slot_close(slot_close),
		.slot_almost(slot_almost), .req_beat(req_beat), .empty_bursts(empty_bursts)
	);

	for (genvar g = 0; g < N; g++) begin : g_slot
		burst_slot u_slot (
			.clk(clk), .rst_n(rst_n),
			.start(slot_start[g]), .fill(slot_fill[g]), .close(slot_close[g]),
			.almost(slot_almost[g]),
			.req_addr(arb_addr), .req_type(arb_type), .req_data(arb_data),
			.req_index(arb_index), .req_beat(req_beat),
			.data_start(data_start[g]), .beat_en(beat_en[g]), .beat_idx(beat_idx),
			.dq_in(dq_in), .done(done[g]),
			.ret_take(ret_take[g]), .ret_beat(ret_beat), .ret_free(ret_free[g]),
			.state(burst_state[g]), .baddr(burst_addr[g]), .btype(burst_type[g]),
			.mask(slot_mask[g]), .beat_word(slot_beat_word[g]),
			.ret_word(slot_ret_word[g]), .ret_idx(slot_ret_idx[g])
		);
	end

	ddr5_cmd_encoder u_enc (
		.clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_slot(cmd_slot),
		.slot_baddr(burst_addr), .slot_type(burst_type), .slot_mask(slot_mask),
		.slot_beat_word(slot_beat_word),
		.cs_n(cs_n), .ca(ca), .dq_out(dq_out), .dq_oe(dq_oe),
		.data_start(data_start), .beat_en(beat_en), .beat_idx(beat_idx), .done(done)
	);

	return_scheduler u_ret (
		.clk(clk), .rst_n(rst_n),
		.slot_state(burst_state), .slot_mask(slot_mask), .slot_type(burst_type),
		.slot_ret_word(slot_ret_word), .slot_ret_idx(slot_ret_idx),
		.ret_take(ret_take), .ret_beat(ret_beat), .ret_free(ret_free),
		.ret_valid(ret_valid), .ret_type(ret_type), .ret_data(ret_data),
		.ret_index(ret_index)
	);

endmodule

`default_nettype wire

// ==== rtl/burst_slot.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "mc_cfg.svh"

module burst_slot (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             start,
	input  logic                             fill,
	input  logic                             close,
	input  logic                             almost,
	input  logic [`MC_ADDR_W-1:0]            req_addr,
	input  mc_pkg::req_type_t                req_type,
	input  logic [`MC_DATA_W-1:0]            req_data,
	input  logic [`MC_INDEX_W-1:0]           req_index,
	input  logic [$clog2(`MC_BURST_LEN)-1:0] req_beat,
	input  logic                             data_start,
	input  logic                             beat_en,
	input  logic [$clog2(`MC_BURST_LEN)-1:0] beat_idx,
	input  logic [`MC_DATA_W-1:0]            dq_in,
	input  logic                             done,
	input  logic                             ret_take,
	input  logic [$clog2(`MC_BURST_LEN)-1:0] ret_beat,
	input  logic                             ret_free,
	output mc_pkg::burst_state_t             state,
	output logic [`MC_BADDR_W-1:0]           baddr,
	output mc_pkg::req_type_t                btype,
	output logic [`MC_BURST_LEN-1:0]         mask,
	output logic [`MC_DATA_W-1:0]            beat_word,
	output logic [`MC_DATA_W-1:0]            ret_word,
	output logic [`MC_INDEX_W-1:0]           ret_idx
);
	logic [`MC_DATA_W-1:0]  data_mem [`MC_BURST_LEN]; // one word per beat
	logic [`MC_INDEX_W-1:0] idx_mem [`MC_BURST_LEN];

	// strobes never overlap for one slot, chain just orders them
	always_ff @(posedge clk) begin
		if (rst_n) begin
			state <= mc_pkg::empty;
			mask <= '0;
		end else begin
			if (start) begin
				state <= mc_pkg::filling;
				mask <= '0;
			end else if (almost && state == mc_pkg::filling) begin
				state <= mc_pkg::almost_done;
			end else if (close) begin
				state <= mc_pkg::full;
			end else if (data_start) begin
				state <= mc_pkg::in_flight;
			end else if (done) begin
				state <= mc_pkg::returning; // last beat moved
			end else if (ret_free) begin
				state <= mc_pkg::empty;
			end
			if (fill) begin
				mask[req_beat] <= 1'b1; // overrides the clear on start
			end
			if (ret_take) begin
				mask[ret_beat] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			baddr <= req_addr[`MC_ADDR_W-1:`MC_ADDR_W-`MC_BADDR_W];
			btype <= req_type;
		end
		if (fill) begin
			idx_mem[req_beat] <= req_index;
			if (req_type == mc_pkg::req_write) begin
				data_mem[req_beat] <= req_data; // reads get their word from dq later
			end
		end
		if (beat_en && mask[beat_idx]) begin
			data_mem[beat_idx] <= dq_in; // read capture, requested beats only
		end
	end

	assign beat_word = data_mem[beat_idx]; // write beat to encoder
	assign ret_word = data_mem[ret_beat];
	assign ret_idx = idx_mem[ret_beat];

endmodule

`default_nettype wire

// ==== rtl/ddr5_cmd_encoder.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "mc_cfg.svh"

module ddr5_cmd_encoder (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  mc_pkg::mem_cmd_t                            cmd,
	input  logic [$clog2(`MC_NUM_BURSTS)-1:0]           cmd_slot,
	input  logic [`MC_NUM_BURSTS-1:0][`MC_BADDR_W-1:0]  slot_baddr,
	input  mc_pkg::req_type_t [`MC_NUM_BURSTS-1:0]      slot_type,
	input  logic [`MC_NUM_BURSTS-1:0][`MC_BURST_LEN-1:0] slot_mask,
	input  logic [`MC_NUM_BURSTS-1:0][`MC_DATA_W-1:0]   slot_beat_word,
	output logic                                        cs_n,
	output logic [13:0]                                 ca,
	output logic [`MC_DATA_W-1:0]                       dq_out,
	output logic                                        dq_oe,
	output logic [`MC_NUM_BURSTS-1:0]                   data_start,
	output logic [`MC_NUM_BURSTS-1:0]                   beat_en,
	output logic [$clog2(`MC_BURST_LEN)-1:0]            beat_idx,
	output logic [`MC_NUM_BURSTS-1:0]                   done
);
	localparam int CNT_W = $clog2(`MC_RD_TO_DATA);

	typedef enum logic [2:0] {ph_idle, ph_one, ph_two, ph_wait, ph_data} phase_t;

	phase_t                             phase;
	mc_pkg::mem_cmd_t                   cmd_q;
	logic [$clog2(`MC_NUM_BURSTS)-1:0]  slot_q;
	logic                               wr_q; // data phase direction
	logic [CNT_W-1:0]                   lat_cnt;
	logic [$clog2(`MC_BURST_LEN)-1:0]   beat;
	logic                               accept;
	logic                               rw_cmd;
	logic [`MC_BADDR_W-1:0]             a_new; // slot addr of incoming cmd
	logic [`MC_BADDR_W-1:0]             a_cur; // slot addr of latched cmd
	logic [13:0]                        ca_p1;
	logic [13:0]                        ca_p2;

	assign accept = phase == ph_idle && cmd != mc_pkg::cmd_none; // busy -> cmd lost
	assign rw_cmd = cmd == mc_pkg::cmd_read || cmd == mc_pkg::cmd_write;
	assign a_new = slot_baddr[cmd_slot];
	assign a_cur = slot_baddr[slot_q];

	// baddr is {bg 25:24, bank 23:22, row 21:6, col[9:4] 5:0}
	always_comb begin
		case (cmd)
			mc_pkg::cmd_activate:  ca_p1 = {2'b00, a_new[9:6], a_new[23:22], a_new[25:24], 4'b0000};
			mc_pkg::cmd_read:      ca_p1 = {5'b10111, 4'b0000, a_new[23:22], a_new[25:24], 1'b0};
			mc_pkg::cmd_write:     ca_p1 = {5'b10110, 4'b0000, a_new[23:22], a_new[25:24], 1'b0};
			mc_pkg::cmd_precharge: ca_p1 = {6'b111011, 1'b0, a_new[23:22], a_new[25:24], 3'b000};
			default:               ca_p1 = '0;
		endcase
		if (cmd_q == mc_pkg::cmd_activate) begin
			ca_p2 = {1'b0, a_cur[21:10], 1'b0}; // row[15:4]
		end else begin
			ca_p2 = {1'b0, a_cur[5:0], 7'b0000000}; // column[9:4]
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			phase <= ph_idle;
			cs_n <= 1'b1;
			ca <= '0;
			cmd_q <= mc_pkg::cmd_none;
			slot_q <= '0;
			wr_q <= 1'b0;
			lat_cnt <= '0;
			beat <= '0;
			done <= '0;
		end else begin
			done <= '0; // single cycle pulse
			case (phase)
				ph_idle: begin
					if (accept) begin
						cs_n <= 1'b0;
						ca <= ca_p1;
						cmd_q <= cmd;
						slot_q <= cmd_slot;
						wr_q <= slot_type[cmd_slot] == mc_pkg::req_write;
						phase <= ph_one;
					end
				end
				ph_one: begin
					cs_n <= 1'b1;
					if (cmd_q == mc_pkg::cmd_precharge) begin
						ca <= '0; // one phase only
						phase <= ph_idle;
					end else begin
						ca <= ca_p2;
						phase <= ph_two;
					end
				end
				ph_two: begin
					ca <= '0;
					// two cycles already spent in ph_two and the switch to ph_data
					lat_cnt <= wr_q ? CNT_W'(`MC_WR_TO_DATA - 2) : CNT_W'(`MC_RD_TO_DATA - 2);
					beat <= '0;
					if (cmd_q == mc_pkg::cmd_read || cmd_q == mc_pkg::cmd_write) begin
						phase <= ph_wait;
					end else begin
						phase <= ph_idle;
					end
				end
				ph_wait: begin
					if (lat_cnt == '0) begin
						phase <= ph_data;
					end else begin
						lat_cnt <= lat_cnt - 1'b1;
					end
				end
				ph_data: begin
					beat <= beat + 1'b1;
					if (beat == $clog2(`MC_BURST_LEN)'(`MC_BURST_LEN - 1)) begin
						done[slot_q] <= 1'b1;
						phase <= ph_idle;
					end
				end
				default: phase <= ph_idle;
			endcase
		end
	end

	// beat b lives in one cycle of ph_data, read word taken at its end
	always_comb begin
		data_start = '0;
		beat_en = '0;
		if (accept && rw_cmd) begin
			data_start[cmd_slot] = 1'b1;
		end
		if (phase == ph_data && !wr_q) begin
			beat_en[slot_q] = 1'b1;
		end
		dq_oe = phase == ph_data && wr_q;
		dq_out = (dq_oe && slot_mask[slot_q][beat]) ? slot_beat_word[slot_q] : '0; // holes -> 0
	end

	assign beat_idx = beat;

endmodule

`default_nettype wire

// ==== rtl/mc_cfg.svh ====
`ifndef MC_CFG_SVH
`define MC_CFG_SVH

// burst slots and beats per burst
`define MC_NUM_BURSTS 4
`define MC_BURST_LEN 16

// request address {bg[1:0], bank[1:0], row[15:0], col[9:0]}
`define MC_ADDR_W 30
`define MC_BADDR_W 26 // address minus col[3:0]

`define MC_DATA_W 16 // one request word, also one dq beat
`define MC_INDEX_W 4 // returner index

// cycles from CA phase 2 to first data beat
`define MC_WR_TO_DATA 8
`define MC_RD_TO_DATA 11

`endif

// ==== rtl/mc_pkg.sv ====
`default_nettype none

package mc_pkg;

	// life of one burst slot
	typedef enum logic [2:0] {
		empty       = 3'd0,
		filling     = 3'd1,
		almost_done = 3'd2, // 8 merges seen
		full        = 3'd3,
		in_flight   = 3'd4, // cmd sent, data phase pending
		returning   = 3'd5
	} burst_state_t;

	typedef enum logic {
		req_read  = 1'b0,
		req_write = 1'b1
	} req_type_t;

	// commands from the timing controller
	typedef enum logic [2:0] {
		cmd_none      = 3'd0,
		cmd_activate  = 3'd1,
		cmd_read      = 3'd2,
		cmd_write     = 3'd3,
		cmd_precharge = 3'd4
	} mem_cmd_t;

endpackage

`default_nettype wire

// ==== rtl/return_scheduler.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "mc_cfg.svh"

module return_scheduler (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  mc_pkg::burst_state_t [`MC_NUM_BURSTS-1:0]    slot_state,
	input  logic [`MC_NUM_BURSTS-1:0][`MC_BURST_LEN-1:0] slot_mask,
	input  mc_pkg::req_type_t [`MC_NUM_BURSTS-1:0]       slot_type,
	input  logic [`MC_NUM_BURSTS-1:0][`MC_DATA_W-1:0]    slot_ret_word,
	input  logic [`MC_NUM_BURSTS-1:0][`MC_INDEX_W-1:0]   slot_ret_idx,
	output logic [`MC_NUM_BURSTS-1:0]                    ret_take,
	output logic [$clog2(`MC_BURST_LEN)-1:0]             ret_beat,
	output logic [`MC_NUM_BURSTS-1:0]                    ret_free,
	output logic                                         ret_valid,
	output mc_pkg::req_type_t                            ret_type,
	output logic [`MC_DATA_W-1:0]                        ret_data,
	output logic [`MC_INDEX_W-1:0]                       ret_index
);
	localparam int SLOT_W = $clog2(`MC_NUM_BURSTS);
	localparam int BEAT_W = $clog2(`MC_BURST_LEN);

	logic [SLOT_W-1:0] pick; // lowest returning slot
	logic              pick_ok;
	logic              bit_ok; // picked slot still has requests

	always_comb begin
		pick = '0;
		pick_ok = 1'b0;
		for (int i = `MC_NUM_BURSTS - 1; i >= 0; i--) begin
			if (slot_state[i] == mc_pkg::returning) begin
				pick = SLOT_W'(i);
				pick_ok = 1'b1;
			end
		end
		ret_beat = '0;
		bit_ok = 1'b0;
		for (int b = `MC_BURST_LEN - 1; b >= 0; b--) begin // lowest beat first
			if (slot_mask[pick][b]) begin
				ret_beat = BEAT_W'(b);
				bit_ok = 1'b1;
			end
		end
		ret_take = '0;
		ret_free = '0;
		if (pick_ok && bit_ok) begin
			ret_take[pick] = 1'b1; // slot drops the mask bit this edge
		end else if (pick_ok) begin
			ret_free[pick] = 1'b1; // all sent, slot back to empty
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			ret_valid <= 1'b0;
		end else begin
			ret_valid <= pick_ok && bit_ok;
		end
	end

	// returner payload, valid qualifies it
	always_ff @(posedge clk) begin
		if (pick_ok && bit_ok) begin
			ret_type <= slot_type[pick];
			ret_data <= slot_ret_word[pick];
			ret_index <= slot_ret_idx[pick];
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the burst_handler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module burst_handler_tb -o sim_tb

# an assertion stop still leaves a log to search
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log || ! grep -q '\*\* PASS \*\*' sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// ==== tb/burst_handler_checker.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "mc_cfg.svh"

module burst_handler_checker (
	input logic                                      clk,
	input logic                                      rst_n,
	input mc_pkg::mem_cmd_t                          cmd, // controller strobe
	input logic                                      cs_n,
	input logic                                      dq_oe,
	input logic                                      ret_valid,
	input mc_pkg::burst_state_t [`MC_NUM_BURSTS-1:0] burst_state,
	input mc_pkg::req_type_t [`MC_NUM_BURSTS-1:0]    burst_type,
	input logic [$clog2(`MC_NUM_BURSTS):0]           empty_bursts
);
	logic                            any_ret;
	logic                            any_flight; // some data phase pending
	logic                            wr_flight;
	logic                            rd_flight;
	logic [$clog2(`MC_NUM_BURSTS):0] n_empty;

	always_comb begin
		any_ret = 1'b0;
		any_flight = 1'b0;
		wr_flight = 1'b0;
		rd_flight = 1'b0;
		n_empty = '0;
		for (int i = 0; i < `MC_NUM_BURSTS; i++) begin
			if (burst_state[i] == mc_pkg::returning) any_ret = 1'b1;
			if (burst_state[i] == mc_pkg::in_flight) begin
				any_flight = 1'b1;
				if (burst_type[i] == mc_pkg::req_write) begin
					wr_flight = 1'b1;
				end else begin
					rd_flight = 1'b1;
				end
			end
			if (burst_state[i] == mc_pkg::empty) n_empty = n_empty + 1'b1;
		end
	end

	// cs_n high for two cycles and nothing in flight means the encoder is idle
	a_phase_one: assert property (@(posedge clk) disable iff (rst_n)
		cmd != mc_pkg::cmd_none && cs_n && $past(cs_n) && !any_flight |=> !cs_n)
		else $error("CHECK FAILED cs_n not low in phase 1");

	a_no_oe_on_read: assert property (@(posedge clk) disable iff (rst_n)
		dq_oe |-> wr_flight && !rd_flight)
		else $error("CHECK FAILED dq_oe high outside a write data phase");

	a_ret_needs_slot: assert property (@(posedge clk) disable iff (rst_n) ret_valid |-> any_ret)
		else $error("CHECK FAILED ret_valid without a returning slot");

	// count of empty slots, so never above the slot count
	a_empty_count: assert property (@(posedge clk) disable iff (rst_n)
		empty_bursts == n_empty)
		else $error("CHECK FAILED empty_bursts %h expected %h", empty_bursts, n_empty);

endmodule

bind burst_handler burst_handler_checker chk_i (
	.clk(clk), .rst_n(rst_n), .cmd(cmd), .cs_n(cs_n), .dq_oe(dq_oe),
	.ret_valid(ret_valid), .burst_state(burst_state), .burst_type(burst_type),
	.empty_bursts(empty_bursts)
);

`default_nettype wire

// ==== tb/burst_handler_tb.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "mc_cfg.svh"

module burst_handler_tb;
	localparam int N = `MC_NUM_BURSTS;

	logic                         clk = 1'b0;
	logic                         rst_n = 1'b1; // high = in reset
	logic                         arb_valid = 1'b0;
	logic [`MC_ADDR_W-1:0]        arb_addr = '0;
	mc_pkg::req_type_t            arb_type = mc_pkg::req_read;
	logic [`MC_DATA_W-1:0]        arb_data = '0;
	logic [`MC_INDEX_W-1:0]       arb_index = '0;
	mc_pkg::mem_cmd_t             cmd = mc_pkg::cmd_none;
	logic [$clog2(N)-1:0]         cmd_slot = '0;
	logic [`MC_DATA_W-1:0]        dq_in = '0;
	logic [$clog2(N):0]           empty_bursts;
	mc_pkg::burst_state_t [N-1:0] burst_state;
	logic [N-1:0][`MC_BADDR_W-1:0] burst_addr;
	mc_pkg::req_type_t [N-1:0]    burst_type;
	logic                         cs_n;
	logic [13:0]                  ca;
	logic [`MC_DATA_W-1:0]        dq_out;
	logic                         dq_oe;
	logic                         ret_valid;
	mc_pkg::req_type_t            ret_type;
	logic [`MC_DATA_W-1:0]        ret_data;
	logic [`MC_INDEX_W-1:0]       ret_index;

	int              errors = 0;
	int              tests = 0;
	int              tests_bad = 0;
	int              err_mark = 0;
	logic [15:0]     lfsr = 16'd52113;
	int              rd_cnt = 0; // cycles since read phase 1 was seen
	logic [15:0]     model_word [16]; // words the memory model sent
	logic [15:0]     wr_word [16]; // expected write beats, holes zero
	logic [3:0]      exp_beat [16];
	logic [3:0]      exp_idx [16];
	logic [15:0]     exp_data [16];

	burst_handler dut_i (.*);

	always #10 clk = ~clk;

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// memory model, timed from read phase 1 seen on cs_n/ca
	always @(posedge clk) begin : read_model
		logic [15:0] w;
		if (rst_n) begin
			rd_cnt <= 0;
			dq_in <= '0;
		end else if (rd_cnt == 0) begin
			if (!cs_n && ca[13:9] == 5'b10111) rd_cnt <= 1;
		end else begin
			rd_cnt <= (rd_cnt == 27) ? 0 : rd_cnt + 1;
			if (rd_cnt >= 11 && rd_cnt <= 26) begin
				for (int i = 0; i < 16; i++) begin // one lfsr step per bit
					w[i] = lfsr[0];
					lfsr = lfsr_step(lfsr);
				end
				model_word[rd_cnt-11] = w;
				dq_in <= w;
			end else begin
				dq_in <= '0;
			end
		end
	end

	function automatic logic [13:0] ca_one(input mc_pkg::mem_cmd_t c, input logic [1:0] bg,
		input logic [1:0] bk, input logic [15:0] row);
		case (c)
			mc_pkg::cmd_activate: return {2'b00, row[3:0], bk, bg, 4'b0000};
			mc_pkg::cmd_read: return {5'b10111, 4'b0000, bk, bg, 1'b0};
			mc_pkg::cmd_write: return {5'b10110, 4'b0000, bk, bg, 1'b0};
			default: return {1'b1, 5'b11011, 1'b0, bk, bg, 3'b000}; // precharge
		endcase
	endfunction

	function automatic logic [13:0] ca_two(input mc_pkg::mem_cmd_t c, input logic [15:0] row,
		input logic [5:0] colh);
		if (c == mc_pkg::cmd_activate) return {1'b0, row[15:4], 1'b0};
		if (c == mc_pkg::cmd_precharge) return 14'd0; // no phase 2
		return {1'b0, colh, 7'b0000000};
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic timed_out(input string what);
		$display("timeout while waiting for %s", what);
		errors++;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != err_mark) tests_bad++;
		$display("test %0d %s: %s", tests, name, errors == err_mark ? "ok" : "errors");
		err_mark = errors;
	endtask

	task automatic send_req(input logic [29:0] a, input mc_pkg::req_type_t t,
		input logic [15:0] d, input logic [3:0] idx);
		@(posedge clk);
		arb_valid <= 1'b1;
		arb_addr <= a;
		arb_type <= t;
		arb_data <= d;
		arb_index <= idx;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		arb_valid <= 1'b0;
	endtask

	task automatic send_cmd(input mc_pkg::mem_cmd_t c, input int slot);
		@(posedge clk);
		cmd <= c;
		cmd_slot <= slot[$clog2(N)-1:0];
		@(posedge clk);
		cmd <= mc_pkg::cmd_none;
	endtask

	task automatic wait_state(input int slot, input mc_pkg::burst_state_t s, input int limit);
		int i;
		for (i = 0; i < limit && burst_state[slot] != s; i++) @(negedge clk);
		if (burst_state[slot] != s) timed_out("a slot state change");
	endtask

	// phase 1 then phase 2, sampled mid cycle
	task automatic check_ca(input logic [13:0] p1, input logic [13:0] p2);
		int i;
		for (i = 0; i < 10 && cs_n; i++) @(negedge clk);
		if (cs_n) begin
			timed_out("cs_n low");
		end else begin
			check_val("ca phase 1", ca, p1);
			@(negedge clk);
			check_val("cs_n phase 2", cs_n, 1'b1);
			check_val("ca phase 2", ca, p2);
		end
	endtask

	task automatic check_returns(input mc_pkg::req_type_t t, input int n);
		int i;
		for (i = 0; i < 60 && !ret_valid; i++) @(negedge clk);
		if (!ret_valid) begin
			timed_out("ret_valid");
		end else begin
			for (int k = 0; k < n; k++) begin
				check_val("ret_valid", ret_valid, 1'b1);
				check_val("ret_index", ret_index, exp_idx[k]);
				check_val("ret_type", ret_type, t);
				check_val("ret_data", ret_data,
					t == mc_pkg::req_write ? exp_data[k] : model_word[exp_beat[k]]);
				@(negedge clk);
			end
			check_val("ret_valid after burst", ret_valid, 1'b0);
		end
	endtask

	initial begin : watchdog
		#2ms;
		$display("simulation ran too long");
		$display("** FAIL **");
		$finish;
	end

	initial begin : stimulus
		int i;
		for (int b = 0; b < 16; b++) wr_word[b] = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b0;
		@(negedge clk);

		check_val("cs_n", cs_n, 1'b1);
		check_val("dq_oe", dq_oe, 1'b0);
		check_val("ret_valid", ret_valid, 1'b0);
		check_val("empty_bursts", empty_bursts, 4);
		for (int s = 0; s < N; s++) check_val("burst_state", burst_state[s], mc_pkg::empty);
		end_test("reset values");

		// slot 0 writes at beats 0, 2, 9; slot 1 reads at beats 1, 4, 15
		send_req({2'd1, 2'd2, 16'h1234, 6'h05, 4'd0}, mc_pkg::req_write, 16'hA5C3, 4'd3);
		send_req({2'd1, 2'd2, 16'h1234, 6'h05, 4'd2}, mc_pkg::req_write, 16'h0F1E, 4'd7);
		send_req({2'd1, 2'd2, 16'h1234, 6'h05, 4'd9}, mc_pkg::req_write, 16'h7E81, 4'd11);
		idle_cycle();
		wait_state(0, mc_pkg::full, 10);
		send_req({2'd2, 2'd1, 16'hBEEF, 6'h2A, 4'd1}, mc_pkg::req_read, 16'h0, 4'd1);
		send_req({2'd2, 2'd1, 16'hBEEF, 6'h2A, 4'd4}, mc_pkg::req_read, 16'h0, 4'd2);
		send_req({2'd2, 2'd1, 16'hBEEF, 6'h2A, 4'd15}, mc_pkg::req_read, 16'h0, 4'd5);
		idle_cycle();
		wait_state(1, mc_pkg::full, 10);
		check_val("burst_addr[0]", burst_addr[0], {2'd1, 2'd2, 16'h1234, 6'h05});
		check_val("burst_addr[1]", burst_addr[1], {2'd2, 2'd1, 16'hBEEF, 6'h2A});

		wr_word[0] = 16'hA5C3;
		wr_word[2] = 16'h0F1E;
		wr_word[9] = 16'h7E81;
		exp_idx[0] = 4'd3;
		exp_idx[1] = 4'd7;
		exp_idx[2] = 4'd11;
		exp_data[0] = 16'hA5C3;
		exp_data[1] = 16'h0F1E;
		exp_data[2] = 16'h7E81;
		send_cmd(mc_pkg::cmd_write, 0);
		check_ca(ca_one(mc_pkg::cmd_write, 2'd1, 2'd2, 16'h1234),
			ca_two(mc_pkg::cmd_write, 16'h1234, 6'h05));
		for (i = 0; i < 20 && !dq_oe; i++) @(negedge clk);
		if (!dq_oe) timed_out("dq_oe");
		for (int b = 0; b < 16; b++) begin
			check_val("dq_oe", dq_oe, 1'b1);
			check_val("dq_out", dq_out, wr_word[b]);
			@(negedge clk);
		end
		check_returns(mc_pkg::req_write, 3);
		end_test("write burst");

		exp_beat[0] = 4'd1;
		exp_beat[1] = 4'd4;
		exp_beat[2] = 4'd15;
		exp_idx[0] = 4'd1;
		exp_idx[1] = 4'd2;
		exp_idx[2] = 4'd5;
		wait_state(0, mc_pkg::empty, 10);
		send_cmd(mc_pkg::cmd_read, 1);
		check_ca(ca_one(mc_pkg::cmd_read, 2'd2, 2'd1, 16'hBEEF),
			ca_two(mc_pkg::cmd_read, 16'hBEEF, 6'h2A));
		check_returns(mc_pkg::req_read, 3);
		end_test("read burst");

		// type change on one address, then eight merges into slot 1
		wait_state(1, mc_pkg::empty, 10);
		send_req({2'd3, 2'd3, 16'h0F0F, 6'h11, 4'd0}, mc_pkg::req_write, 16'h1111, 4'd0);
		for (int c = 1; c <= 9; c++) begin
			send_req({2'd3, 2'd3, 16'h0F0F, 6'h11, 4'(c)}, mc_pkg::req_read, 16'h0, 4'(c));
		end
		idle_cycle();
		@(negedge clk);
		check_val("burst_state[0]", burst_state[0], mc_pkg::full);
		check_val("burst_state[1]", burst_state[1], mc_pkg::almost_done);
		check_val("burst_type[1]", burst_type[1], mc_pkg::req_read);
		check_val("burst_addr[1]", burst_addr[1], {2'd3, 2'd3, 16'h0F0F, 6'h11});
		end_test("merge break");

		send_cmd(mc_pkg::cmd_activate, 0);
		check_ca(ca_one(mc_pkg::cmd_activate, 2'd3, 2'd3, 16'h0F0F),
			ca_two(mc_pkg::cmd_activate, 16'h0F0F, 6'h11));
		send_cmd(mc_pkg::cmd_precharge, 1);
		check_ca(ca_one(mc_pkg::cmd_precharge, 2'd3, 2'd3, 16'h0F0F),
			ca_two(mc_pkg::cmd_precharge, 16'h0F0F, 6'h11));
		end_test("activate and precharge");

		send_cmd(mc_pkg::cmd_write, 0);
		wait_state(0, mc_pkg::empty, 80);
		send_cmd(mc_pkg::cmd_read, 1);
		wait_state(1, mc_pkg::empty, 80);
		for (i = 0; i < 10 && empty_bursts != 4; i++) @(negedge clk);
		check_val("empty_bursts", empty_bursts, 4);
		send_req({2'd0, 2'd1, 16'h4321, 6'h3F, 4'd6}, mc_pkg::req_write, 16'h5A5A, 4'd9);
		idle_cycle();
		@(negedge clk);
		check_val("burst_state[0]", burst_state[0], mc_pkg::filling);
		check_val("empty_bursts", empty_bursts, 3);
		end_test("slot reuse");

		repeat (3) @(negedge clk);
		$display("tests %0d, failed %0d, errors %0d", tests, tests_bad, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire
